//--- source/psram_pkg.sv
// Shared types for the Wishbone to PSRAM bridge
// Request and pin-side structs, controller states and address widths
`default_nettype none

package psram_pkg;

    // Device halfword address width (8M x 16)
    localparam int MEM_ADDR_W = 23;

    // Word address taken from Wishbone adr bits 23..2
    localparam int WORD_ADDR_W = MEM_ADDR_W - 1;

    // One captured Wishbone request
    typedef struct packed {
        logic                   we;
        logic [3:0]             sel;
        logic [WORD_ADDR_W-1:0] word_addr;
        logic [31:0]            wdata;
    } mem_req_t;

    // Device-side outputs of the cycle engine
    // All strobes and byte enables are active low
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] a;
        logic                  cen;
        logic                  oen;
        logic                  wen;
        logic                  ub_n;
        logic                  lb_n;
        logic [15:0]           dq_out;
        // High while the bridge owns the data bus
        logic                  dq_oe;
    } psram_bus_t;

    // Asynchronous halfword cycle states
    typedef enum logic [2:0] {
        // Waiting for a request
        ST_IDLE,
        // Address and byte enables settle, CEN low
        ST_SETUP,
        // OEN or WEN held low
        ST_STROBE,
        // Strobes back high for one cycle
        ST_RECOVER,
        // Request finished, done pulse
        ST_DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- source/psram_wb_slave.sv
// Wishbone classic slave front end for the PSRAM bridge
// Captures one request, waits for the controller, returns a single-cycle ack
`default_nettype none

module psram_wb_slave (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    // Wishbone classic
    input  wire                  cyc_i,
    input  wire                  stb_i,
    input  wire                  we_i,
    input  wire  [3:0]           sel_i,
    input  wire  [31:0]          adr_i,
    input  wire  [31:0]          dat_i,
    output logic [31:0]          dat_o,
    output logic                 ack_o,
    // Controller side
    input  wire                  req_done_i,
    input  wire  [31:0]          rdata_i,
    output logic                 req_valid_o,
    output psram_pkg::mem_req_t  req_o
);

    import psram_pkg::*;

    typedef enum logic [1:0] {
        SL_IDLE,
        SL_BUSY,
        SL_ACK,
        SL_BLOCK
    } slave_state_e;

    slave_state_e state_q;
    logic         bus_req;

    assign bus_req = cyc_i && stb_i;

    // Handshake sequence
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= SL_IDLE;
        end else begin
            case (state_q)
                SL_IDLE: begin
                    if (bus_req) begin
                        state_q <= SL_BUSY;
                    end
                end
                SL_BUSY: begin
                    if (req_done_i) begin
                        state_q <= SL_ACK;
                    end
                end
                SL_ACK: begin
                    state_q <= SL_BLOCK;
                end
                // Master may still hold stb here, so do not sample it
                SL_BLOCK: begin
                    state_q <= SL_IDLE;
                end
                default: begin
                    state_q <= SL_IDLE;
                end
            endcase
        end
    end

    // Request payload, byte offset of the address dropped
    always_ff @(posedge clk_i) begin
        if (state_q == SL_IDLE && bus_req) begin
            req_o.we        <= we_i;
            req_o.sel       <= sel_i;
            req_o.word_addr <= adr_i[WORD_ADDR_W+1:2];
            req_o.wdata     <= dat_i;
        end
    end

    // Read data is registered together with ack
    always_ff @(posedge clk_i) begin
        if (state_q == SL_BUSY && req_done_i) begin
            dat_o <= rdata_i;
        end
    end

    assign ack_o       = (state_q == SL_ACK);
    assign req_valid_o = (state_q == SL_BUSY);

endmodule

`default_nettype wire

//--- source/psram_ctrl.sv
// Asynchronous PSRAM cycle engine
// Splits a 32-bit request into one or two 16-bit device cycles
// and times setup, strobe and recovery in clock cycles
`default_nettype none

module psram_ctrl #(
    parameter int T_READ  = 7,
    parameter int T_WRITE = 6
) (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    // Request from the Wishbone slave
    input  wire                    req_valid_i,
    input  wire psram_pkg::mem_req_t req_i,
    output logic                   req_done_o,
    output logic [31:0]            rdata_o,
    // Device side
    input  wire  [15:0]            rd_dq_i,
    output psram_pkg::psram_bus_t  bus_o
);

    import psram_pkg::*;

    // Counter holds up to the longer strobe minus one
    localparam int T_MAX = (T_READ > T_WRITE) ? T_READ : T_WRITE;
    localparam int CNT_W = (T_MAX > 2) ? $clog2(T_MAX) : 1;

    ctrl_state_e       state_q;
    logic [CNT_W-1:0]  cnt_q;
    // Current halfword, 0 is the low half at the even address
    logic              half_q;
    // Current halfword is the final one of the request
    logic              last_q;

    mem_req_t          req_q;
    logic [31:0]       rdata_q;

    logic              lo_empty;
    logic              hi_empty;
    logic              active;
    logic              strobe_end;
    logic [1:0]        half_sel;

    // A write skips a halfword whose two selects are both zero
    assign lo_empty = req_i.we && (req_i.sel[1:0] == 2'b00);
    assign hi_empty = req_i.we && (req_i.sel[3:2] == 2'b00);

    assign strobe_end = (state_q == ST_STROBE) && (cnt_q == '0);

    // State machine and strobe counter
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            half_q  <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        if (lo_empty && hi_empty) begin
                            // Nothing to write, finish at once
                            state_q <= ST_DONE;
                        end else begin
                            state_q <= ST_SETUP;
                        end
                        half_q <= lo_empty;
                        last_q <= lo_empty || hi_empty;
                    end
                end
                ST_SETUP: begin
                    if (req_q.we) begin
                        cnt_q <= CNT_W'(T_WRITE - 1);
                    end else begin
                        cnt_q <= CNT_W'(T_READ - 1);
                    end
                    state_q <= ST_STROBE;
                end
                ST_STROBE: begin
                    if (cnt_q == '0) begin
                        state_q <= ST_RECOVER;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                ST_RECOVER: begin
                    if (last_q) begin
                        state_q <= ST_DONE;
                    end else begin
                        // Move on to the odd halfword
                        half_q  <= 1'b1;
                        last_q  <= 1'b1;
                        state_q <= ST_SETUP;
                    end
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Request copy taken when the engine leaves idle
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && req_valid_i) begin
            req_q <= req_i;
        end
    end

    // Read data sampled on the last strobe cycle
    always_ff @(posedge clk_i) begin
        if (strobe_end && !req_q.we) begin
            if (half_q) begin
                rdata_q[31:16] <= rd_dq_i;
            end else begin
                rdata_q[15:0] <= rd_dq_i;
            end
        end
    end

    assign active = (state_q == ST_SETUP) ||
                    (state_q == ST_STROBE) ||
                    (state_q == ST_RECOVER);

    // Byte selects of the halfword in flight
    assign half_sel = half_q ? req_q.sel[3:2] : req_q.sel[1:0];

    // Pin side, all from registered state
    always_comb begin
        bus_o.a      = {req_q.word_addr, half_q};
        bus_o.cen    = !active;
        bus_o.oen    = !((state_q == ST_STROBE) && !req_q.we);
        bus_o.wen    = !((state_q == ST_STROBE) && req_q.we);
        bus_o.ub_n   = !(active && half_sel[1]);
        bus_o.lb_n   = !(active && half_sel[0]);
        bus_o.dq_out = half_q ? req_q.wdata[31:16] : req_q.wdata[15:0];
        // Write data held through setup, strobe and recovery
        bus_o.dq_oe  = active && req_q.we;
    end

    assign req_done_o = (state_q == ST_DONE);
    assign rdata_o    = rdata_q;

endmodule

`default_nettype wire

//--- source/psram_top.sv
// Wishbone to asynchronous CellularRAM bridge
// Joins the bus slave and the cycle engine and drives the device pins
`default_nettype none

module psram_top #(
    parameter int T_READ  = 7,
    parameter int T_WRITE = 6
) (
    input  wire         clk_i,
    input  wire         rst_n_i,
    // Wishbone classic slave
    input  wire         cyc_i,
    input  wire         stb_i,
    input  wire         we_i,
    input  wire  [3:0]  sel_i,
    input  wire  [31:0] adr_i,
    input  wire  [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o,
    // CellularRAM pins
    output logic [22:0] Mem_A,
    inout  wire  [15:0] Mem_DQ,
    output logic        Mem_CEN,
    output logic        Mem_OEN,
    output logic        Mem_WEN,
    output logic        Mem_UB,
    output logic        Mem_LB,
    output logic        Mem_ADV,
    output logic        Mem_CLK,
    output logic        Mem_CRE
);

    import psram_pkg::*;

    logic        req_valid;
    mem_req_t    req;
    logic        req_done;
    logic [31:0] rdata;
    psram_bus_t  bus;
    logic [15:0] rd_dq;

    psram_wb_slave wb_slave0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cyc_i       (cyc_i),
        .stb_i       (stb_i),
        .we_i        (we_i),
        .sel_i       (sel_i),
        .adr_i       (adr_i),
        .dat_i       (dat_i),
        .dat_o       (dat_o),
        .ack_o       (ack_o),
        .req_done_i  (req_done),
        .rdata_i     (rdata),
        .req_valid_o (req_valid),
        .req_o       (req)
    );

    psram_ctrl #(
        .T_READ  (T_READ),
        .T_WRITE (T_WRITE)
    ) ctrl0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_done_o  (req_done),
        .rdata_o     (rdata),
        .rd_dq_i     (rd_dq),
        .bus_o       (bus)
    );

    assign Mem_A   = bus.a;
    assign Mem_CEN = bus.cen;
    assign Mem_OEN = bus.oen;
    assign Mem_WEN = bus.wen;
    assign Mem_UB  = bus.ub_n;
    assign Mem_LB  = bus.lb_n;

    // Asynchronous mode: no device clock, address always latched
    assign Mem_ADV = 1'b0;
    assign Mem_CLK = 1'b0;
    assign Mem_CRE = 1'b0;

    // Bidirectional data bus
    assign Mem_DQ = bus.dq_oe ? bus.dq_out : 16'bz;
    assign rd_dq  = Mem_DQ;

endmodule

`default_nettype wire

//--- verif/psram_model.sv
// Behavioral asynchronous CellularRAM
// Stores halfwords, writes on the rising edge of WEN and drives DQ while CEN and OEN are low
`default_nettype none

module psram_model (
    input  wire  [22:0] a_i,
    inout  wire  [15:0] dq_io,
    input  wire         cen_i,
    input  wire         oen_i,
    input  wire         wen_i,
    input  wire         ub_n_i,
    input  wire         lb_n_i
);

    logic [15:0] mem [logic [22:0]];
    logic [15:0] rd_half;

    // Contents of a halfword that was never written
    function automatic logic [15:0] fill_half(input logic [22:0] addr);
        return addr[15:0] ^ {addr[22:16], 9'h155};
    endfunction

    function automatic logic [15:0] read_half(input logic [22:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return fill_half(addr);
    endfunction

    // Write takes the enabled byte lanes only
    always @(posedge wen_i) begin
        logic [15:0] cur;
        if (cen_i === 1'b0) begin
            cur = read_half(a_i);
            if (!lb_n_i) begin
                cur[7:0] = dq_io[7:0];
            end
            if (!ub_n_i) begin
                cur[15:8] = dq_io[15:8];
            end
            mem[a_i] = cur;
        end
    end

    // Address is stable from setup on, so fetch when the read strobe falls
    always @(negedge oen_i) begin
        rd_half = read_half(a_i);
    end

    assign dq_io = (!cen_i && !oen_i) ? rd_half : 16'bz;

endmodule

`default_nettype wire

//--- verif/psram_assertions.sv
// Protocol checks for the PSRAM bridge bound into the top level
// Wishbone ack rules and asynchronous pin timing
`default_nettype none

module psram_assertions #(
    parameter int T_READ  = 7,
    parameter int T_WRITE = 6
) (
    input wire        clk_i,
    input wire        rst_n_i,
    input wire        cyc_i,
    input wire        stb_i,
    input wire        ack_i,
    input wire [22:0] mem_a_i,
    input wire        mem_oen_i,
    input wire        mem_wen_i
);

    int   failures = 0;
    int   oen_low_cnt;
    int   wen_low_cnt;
    logic strobe_low;

    assign strobe_low = !mem_oen_i || !mem_wen_i;

    // Number of clock edges each strobe has been seen low
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            oen_low_cnt <= 0;
            wen_low_cnt <= 0;
        end else begin
            oen_low_cnt <= mem_oen_i ? 0 : oen_low_cnt + 1;
            wen_low_cnt <= mem_wen_i ? 0 : wen_low_cnt + 1;
        end
    end

    ack_needs_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |-> (cyc_i && stb_i))
        else begin
            $error("ack high without cyc and stb");
            failures++;
        end

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else begin
            $error("ack longer than one cycle");
            failures++;
        end

    no_strobe_overlap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_oen_i || mem_wen_i)
        else begin
            $error("OEN and WEN low together");
            failures++;
        end

    addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (strobe_low && $past(strobe_low)) |-> $stable(mem_a_i))
        else begin
            $error("address changed during a strobe");
            failures++;
        end

    read_width: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(mem_oen_i) |-> (oen_low_cnt >= T_READ))
        else begin
            $error("read strobe too short");
            failures++;
        end

    write_width: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(mem_wen_i) |-> (wen_low_cnt >= T_WRITE))
        else begin
            $error("write strobe too short");
            failures++;
        end

endmodule

bind psram_top psram_assertions #(
    .T_READ  (T_READ),
    .T_WRITE (T_WRITE)
) assertions0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .ack_i     (ack_o),
    .mem_a_i   (Mem_A),
    .mem_oen_i (Mem_OEN),
    .mem_wen_i (Mem_WEN)
);

`default_nettype wire

//--- verif/psram_tb.sv
// Testbench for the Wishbone to PSRAM bridge
// Drives Wishbone reads and writes and checks reads against a reference memory
`default_nettype none

module psram_tb;

    import psram_pkg::*;

    localparam int ACK_TIMEOUT = 200;

    logic        clk;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] wdata;
    wire  [31:0] rdata;
    wire         ack;
    wire  [22:0] mem_a;
    wire  [15:0] mem_dq;
    wire         mem_cen;
    wire         mem_oen;
    wire         mem_wen;
    wire         mem_ub;
    wire         mem_lb;
    wire         mem_adv;
    wire         mem_clk;
    wire         mem_cre;

    int seed = 43779;
    int errors = 0;
    int checks = 0;
    logic [31:0]            ref_mem [logic [WORD_ADDR_W-1:0]];
    logic [WORD_ADDR_W-1:0] used_addrs [$];

    psram_top dut0 (
        .clk_i (clk), .rst_n_i (rst_n), .cyc_i (cyc), .stb_i (stb), .we_i (we),
        .sel_i (sel), .adr_i (adr), .dat_i (wdata), .dat_o (rdata), .ack_o (ack),
        .Mem_A (mem_a), .Mem_DQ (mem_dq), .Mem_CEN (mem_cen), .Mem_OEN (mem_oen),
        .Mem_WEN (mem_wen), .Mem_UB (mem_ub), .Mem_LB (mem_lb), .Mem_ADV (mem_adv),
        .Mem_CLK (mem_clk), .Mem_CRE (mem_cre)
    );

    psram_model model0 (
        .a_i (mem_a), .dq_io (mem_dq), .cen_i (mem_cen), .oen_i (mem_oen),
        .wen_i (mem_wen), .ub_n_i (mem_ub), .lb_n_i (mem_lb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [15:0] fill_half(input logic [22:0] addr);
        return addr[15:0] ^ {addr[22:16], 9'h155};
    endfunction

    // Unwritten words read back as the model fill pattern
    function automatic logic [31:0] expected_word(input logic [WORD_ADDR_W-1:0] wa);
        if (ref_mem.exists(wa)) begin
            return ref_mem[wa];
        end
        return {fill_half({wa, 1'b1}), fill_half({wa, 1'b0})};
    endfunction

    function automatic void update_ref(input logic [WORD_ADDR_W-1:0] wa,
                                       input logic [31:0] data, input logic [3:0] be);
        logic [31:0] word;
        word = expected_word(wa);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                word[8*i +: 8] = data[8*i +: 8];
            end
        end
        ref_mem[wa] = word;
    endfunction

    // Poll ack on each falling edge until it arrives or the timeout expires
    task automatic wait_ack(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            seen = (ack === 1'b1);
            cycles++;
        end
    endtask

    task automatic bus_cycle(input logic is_write, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] be,
                             output logic [31:0] rd);
        bit seen;
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we = is_write;
        sel = be;
        adr = addr;
        wdata = data;
        wait_ack(seen);
        rd = rdata;
        if (!seen) begin
            $display("Timeout at time %0t: ack never came for access at %h", $time, addr);
            errors++;
        end
        // Strobe stays up over the edge that ends ack
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, data, be, unused);
        update_ref(addr[23:2], data, be);
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [31:0] got;
        logic [31:0] exp;
        exp = expected_word(addr[23:2]);
        bus_cycle(1'b0, addr, 32'h0, 4'hf, got);
        checks++;
        assert (got === exp) else begin
            $display("Fail at time %0t: read at %h gave %h, expected %h", $time, addr, got, exp);
            errors++;
        end
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] pick;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        sel = 4'h0;
        adr = 32'h0;
        wdata = 32'h0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        assert (ack === 1'b0) else begin
            $display("Fail at time %0t: ack high after reset", $time);
            errors++;
        end
        assert (mem_cen === 1'b1 && mem_oen === 1'b1 && mem_wen === 1'b1) else begin
            $display("Fail at time %0t: device strobes not idle after reset", $time);
            errors++;
        end
        // Asynchronous mode keeps ADV, CLK and CRE low
        assert (mem_adv === 1'b0 && mem_clk === 1'b0 && mem_cre === 1'b0) else begin
            $display("Fail at time %0t: ADV, CLK or CRE not held low", $time);
            errors++;
        end

        addr = 32'h0000_1230;
        write_word(addr, 32'hdead_beef, 4'hf);
        read_check(addr);
        // Selects 0001 and 0100 issue a single halfword cycle
        write_word(addr, 32'h1122_3344, 4'b0001);
        read_check(addr);
        write_word(addr, 32'h5566_7788, 4'b0100);
        read_check(addr);
        write_word(addr, 32'h99aa_bbcc, 4'b1100);
        read_check(addr);

        // Bits outside 23..2 are random and must be ignored
        for (int i = 0; i < 40; i++) begin
            pick = $random(seed);
            addr = $random(seed);
            if (pick[0] && used_addrs.size() > 0) begin
                addr[23:2] = used_addrs[pick[15:8] % used_addrs.size()];
            end
            if (pick[1]) begin
                write_word(addr, $random(seed), 4'($random(seed)));
                used_addrs.push_back(addr[23:2]);
            end else begin
                read_check(addr);
            end
        end

        $display("Read checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.assertions0.failures);
        if (errors == 0 && dut0.assertions0.failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
source/psram_pkg.sv
source/psram_wb_slave.sv
source/psram_ctrl.sv
source/psram_top.sv
verif/psram_model.sv
verif/psram_assertions.sv
verif/psram_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= psram_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

FAIL_MSG := Finished with errors
PASS_MSG := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -qx "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
